//--- tests/pipe_debug_golden.txt
# P <latch port> <hex value> | F <freeze level> | C <code hex> <expected word hex> <error flag>
# one line per clock, a read sees every line above it
P if_pc 00400010
P if_instr 8c220004
P id_exe 2a
P id_mem 2
P id_wb 15
P id_pc 0040000c
P id_reg_a 12345678
P id_reg_b 9abcdef0
P id_instr_ls 00000004
P id_rs 11
P id_rt 0a
P id_rd 1f
P id_pc_write 1
P id_if_id_write 0
P ex_wb 0c
P ex_mem 5
P ex_pc_jump 00400100
P ex_alu_result cafe0001
P ex_alu_zero 1
P ex_reg_b 0000beef
P ex_regf_wreg 13
P mem_wb 1e
P mem_pc_sel 1
P mem_regf_wd 00001000
P mem_alu_result deadbeef
P mem_regf_wreg 07
P wb_regf_wr 1
P wb_regf_wd 5555aaaa
# every legal code, back to back, ex index 2 is the hole
C 00 00400010 0
C 01 8c220004 0
C 10 002a0215 0
C 11 0040000c 0
C 12 12345678 0
C 13 9abcdef0 0
C 14 00000004 0
C 15 110a1f02 0
C 20 0000050c 0
C 21 00400100 0
C 22 00000000 0
C 23 cafe0001 0
C 24 0000beef 0
C 25 00000113 0
C 30 0000001e 0
C 31 00001000 0
C 32 deadbeef 0
C 33 00000107 0
C 40 5555aaaa 0
C 41 00000001 0
# index past the count, stage past wb
C 02 00000000 1
C 16 00000000 1
C 26 00000000 1
C 34 00000000 1
C 42 00000000 1
C 50 00000000 1
C 7f 00000000 1
# frozen picture, then release
F 1
P if_pc 11111111
P mem_alu_result 0badf00d
C 00 00400010 0
C 32 deadbeef 0
F 0
C 00 11111111 0
C 32 0badf00d 0

//--- all.f
+incdir+include
design/dbg_pkg.sv
design/pipe_pkg.sv
design/dbg_sel_if.sv
design/dbg_cmd_decoder.sv
design/stage_snapshot.sv
design/dbg_readout_mux.sv
design/pipe_debug_top.sv
tests/tb_pipe_debug.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the debug readout testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	-f all.f \
	--top-module tb_pipe_debug \
	--Mdir "$BUILD_DIR" \
	-o sim_tb_pipe_debug

"./$BUILD_DIR/sim_tb_pipe_debug" | tee "$LOG"

if grep -qx "test passed" "$LOG"; then
	exit 0
fi
echo "simulation did not report success, see $LOG"
exit 1

//--- tests/tb_pipe_debug.sv
`include "dbg_params.svh"

module tb_pipe_debug;

	timeunit 1ns;
	timeprecision 1ps;

	localparam string GOLDEN_PATH = "tests/pipe_debug_golden.txt";

	logic                   clk;
	logic                   rst;
	logic                   cmd_valid;
	logic [`DBG_CODE_W-1:0] cmd_code;
	logic                   freeze;

	// latch fields, all start at zero
	logic [31:0] if_pc = '0, if_instr = '0;
	logic [4:0]  id_wb = '0, id_rs = '0, id_rt = '0, id_rd = '0;
	logic [1:0]  id_mem = '0;
	logic [5:0]  id_exe = '0;
	logic [31:0] id_pc = '0, id_reg_a = '0, id_reg_b = '0, id_instr_ls = '0;
	logic        id_pc_write = 1'b0, id_if_id_write = 1'b0;
	logic [4:0]  ex_wb = '0, ex_regf_wreg = '0;
	logic [2:0]  ex_mem = '0;
	logic [31:0] ex_pc_jump = '0, ex_alu_result = '0, ex_reg_b = '0;
	logic        ex_alu_zero = 1'b0;
	logic [4:0]  mem_wb = '0, mem_regf_wreg = '0;
	logic        mem_pc_sel = 1'b0;
	logic [31:0] mem_regf_wd = '0, mem_alu_result = '0;
	logic        wb_regf_wr = 1'b0;
	logic [31:0] wb_regf_wd = '0;

	logic [`DBG_WORD_W-1:0] out_data;
	logic                   out_valid;
	logic                   cmd_error;

	// reads in flight, oldest first
	logic [31:0]            exp_data_q [$];
	logic                   exp_err_q  [$];
	logic [`DBG_CODE_W-1:0] exp_code_q [$];

	// golden steps as parsed
	string       step_kind [$];
	string       step_name [$];
	logic [31:0] step_a [$];  // value, level or code
	logic [31:0] step_b [$];  // expected word
	logic [31:0] step_c [$];  // expected error flag

	int unsigned cycle_limit = 0;
	int unsigned checks = 0;
	int unsigned err_data = 0;
	int unsigned err_flag = 0;
	int unsigned err_timing = 0;
	int unsigned err_other = 0;
	logic [1:0]  valid_hist = 2'b00;  // cmd_valid, last two cycles

	pipe_debug_top pipe_debug_top_i (.*);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;  // 40 ns period
	end

	////////////////////
	// golden file
	////////////////////

	task automatic load_golden();
		int          fd;
		int          n;
		int          need;
		string       line;
		string       tok;
		string       name;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		fd = $fopen(GOLDEN_PATH, "r");
		if (fd == 0)
		begin
			$display("cannot open %s, no stimulus to run", GOLDEN_PATH);
			err_other++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			tok  = "";
			name = "";
			a    = '0;
			b    = '0;
			c    = '0;
			n    = $fgets(line, fd);
			n    = $sscanf(line, "%s", tok);
			if (n < 1 || tok.len() == 0 || tok.substr(0, 0) == "#")
				continue;  // blank or comment
			if (tok == "P")
			begin
				need = 3;
				n    = $sscanf(line, "%s %s %h", tok, name, a);
			end
			else if (tok == "F")
			begin
				need = 2;
				n    = $sscanf(line, "%s %h", tok, a);
			end
			else if (tok == "C")
			begin
				need = 4;
				n    = $sscanf(line, "%s %h %h %h", tok, a, b, c);
			end
			else
			begin
				$display("golden file has a line of unknown kind %s", tok);
				err_other++;
				continue;
			end
			if (n != need)
			begin
				$display("golden file line is missing columns: %s", line);
				err_other++;
				continue;
			end
			step_kind.push_back(tok);
			step_name.push_back(name);
			step_a.push_back(a);
			step_b.push_back(b);
			step_c.push_back(c);
		end
		$fclose(fd);
	endtask

	// one latch port by name, cut to its width
	task automatic set_latch(input string name, input logic [31:0] v);
		case (name)
			"if_pc":          if_pc <= v;
			"if_instr":       if_instr <= v;
			"id_wb":          id_wb <= v[4:0];
			"id_mem":         id_mem <= v[1:0];
			"id_exe":         id_exe <= v[5:0];
			"id_pc":          id_pc <= v;
			"id_reg_a":       id_reg_a <= v;
			"id_reg_b":       id_reg_b <= v;
			"id_instr_ls":    id_instr_ls <= v;
			"id_rs":          id_rs <= v[4:0];
			"id_rt":          id_rt <= v[4:0];
			"id_rd":          id_rd <= v[4:0];
			"id_pc_write":    id_pc_write <= v[0];
			"id_if_id_write": id_if_id_write <= v[0];
			"ex_wb":          ex_wb <= v[4:0];
			"ex_mem":         ex_mem <= v[2:0];
			"ex_pc_jump":     ex_pc_jump <= v;
			"ex_alu_result":  ex_alu_result <= v;
			"ex_alu_zero":    ex_alu_zero <= v[0];
			"ex_reg_b":       ex_reg_b <= v;
			"ex_regf_wreg":   ex_regf_wreg <= v[4:0];
			"mem_wb":         mem_wb <= v[4:0];
			"mem_pc_sel":     mem_pc_sel <= v[0];
			"mem_regf_wd":    mem_regf_wd <= v;
			"mem_alu_result": mem_alu_result <= v;
			"mem_regf_wreg":  mem_regf_wreg <= v[4:0];
			"wb_regf_wr":     wb_regf_wr <= v[0];
			"wb_regf_wd":     wb_regf_wd <= v;
			default:
			begin
				$display("golden file names an unknown latch port %s", name);
				err_other++;
			end
		endcase
	endtask

	////////////////////
	// checks
	////////////////////

	task automatic check_idle();
		checks++;
		if (out_valid !== 1'b0)
		begin
			$display("[ERROR] %0t out_valid: got %b expected 0", $time, out_valid);
			err_timing++;
		end
		if (cmd_error !== 1'b0)
		begin
			$display("[ERROR] %0t cmd_error: got %b expected 0", $time, cmd_error);
			err_flag++;
		end
		if (out_data !== '0)
		begin
			$display("[ERROR] %0t out_data: got %h expected 00000000", $time, out_data);
			err_data++;
		end
	endtask

	// compare a read against the oldest command
	task automatic check_read();
		logic [31:0]            want;
		logic                   want_err;
		logic [`DBG_CODE_W-1:0] code;
		if (exp_data_q.size() == 0)
		begin
			$display("a read word appeared at %0t with no command outstanding", $time);
			err_timing++;
			return;
		end
		want     = exp_data_q.pop_front();
		want_err = exp_err_q.pop_front();
		code     = exp_code_q.pop_front();
		checks++;
		if (out_data !== want)
		begin
			$display("[ERROR] %0t out_data: got %h expected %h, code %h",
				$time, out_data, want, code);
			err_data++;
		end
		if (cmd_error !== want_err)
		begin
			$display("[ERROR] %0t cmd_error: got %b expected %b, code %h",
				$time, cmd_error, want_err, code);
			err_flag++;
		end
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (out_valid !== valid_hist[1])  // fixed 2 cycle latency
			begin
				$display("[ERROR] %0t out_valid: got %b expected %b",
					$time, out_valid, valid_hist[1]);
				err_timing++;
			end
			if (out_valid === 1'b1)
				check_read();
			else if (cmd_error !== 1'b0)
			begin
				$display("[ERROR] %0t cmd_error: got %b expected 0", $time, cmd_error);
				err_flag++;
			end
		end
		valid_hist = {valid_hist[0], cmd_valid};
	end

	////////////////////
	// stimulus
	////////////////////

	initial
	begin
		rst       = 1'b1;
		cmd_valid = 1'b0;
		cmd_code  = '0;
		freeze    = 1'b0;
		load_golden();
		cycle_limit = step_kind.size() * 4 + 50;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_idle();  // clean after reset

		// one golden line per cycle
		for (int i = 0; i < step_kind.size(); i++)
		begin
			@(posedge clk);
			cmd_valid <= 1'b0;
			case (step_kind[i])
				"P": set_latch(step_name[i], step_a[i]);
				"F": freeze <= step_a[i][0];
				default:
				begin
					cmd_valid <= 1'b1;
					cmd_code  <= step_a[i][`DBG_CODE_W-1:0];
					exp_code_q.push_back(step_a[i][`DBG_CODE_W-1:0]);
					exp_data_q.push_back(step_b[i]);
					exp_err_q.push_back(step_c[i][0]);
				end
			endcase
		end
		@(posedge clk);
		cmd_valid <= 1'b0;

		// drain the last reads, watchdog catches a stuck pipe
		while (exp_data_q.size() != 0)
			@(negedge clk);
		repeat (3) @(negedge clk);  // no stray valid after that

		$display("checks %0d, errors data %0d flag %0d timing %0d other %0d",
			checks, err_data, err_flag, err_timing, err_other);
		if (err_data + err_flag + err_timing + err_other == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial
	begin : watchdog
		int unsigned cycle;
		cycle = 0;
		wait (cycle_limit != 0);
		while (cycle < cycle_limit)
		begin
			@(posedge clk);
			cycle++;
		end
		$display("run did not finish within %0d cycles", cycle);
		$display("test failed");
		$finish;
	end

endmodule

//--- design/pipe_debug_top.sv
`include "dbg_params.svh"

module pipe_debug_top
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,
	input  logic [`DBG_CODE_W-1:0] cmd_code,
	input  logic                   freeze,

	// fetch
	input  logic [31:0]            if_pc,
	input  logic [31:0]            if_instr,
	// decode
	input  logic [4:0]             id_wb,
	input  logic [1:0]             id_mem,
	input  logic [5:0]             id_exe,
	input  logic [31:0]            id_pc,
	input  logic [31:0]            id_reg_a,
	input  logic [31:0]            id_reg_b,
	input  logic [31:0]            id_instr_ls,
	input  logic [4:0]             id_rs,
	input  logic [4:0]             id_rt,
	input  logic [4:0]             id_rd,
	input  logic                   id_pc_write,
	input  logic                   id_if_id_write,
	// execute
	input  logic [4:0]             ex_wb,
	input  logic [2:0]             ex_mem,
	input  logic [31:0]            ex_pc_jump,
	input  logic [31:0]            ex_alu_result,
	input  logic                   ex_alu_zero,
	input  logic [31:0]            ex_reg_b,
	input  logic [4:0]             ex_regf_wreg,
	// memory
	input  logic [4:0]             mem_wb,
	input  logic                   mem_pc_sel,
	input  logic [31:0]            mem_regf_wd,
	input  logic [31:0]            mem_alu_result,
	input  logic [4:0]             mem_regf_wreg,
	// write back
	input  logic                   wb_regf_wr,
	input  logic [31:0]            wb_regf_wd,

	output logic [`DBG_WORD_W-1:0] out_data,
	output logic                   out_valid,
	output logic                   cmd_error
);

	pipe_pkg::stage_words_t latch_words [`DBG_NUM_STAGES];
	pipe_pkg::word_t        stage_word  [`DBG_NUM_STAGES];

	dbg_sel_if sel_if ();

	////////////////////
	// latch packing
	////////////////////

	always_comb
	begin
		latch_words = '{default: '0};  // unused slots stay zero

		latch_words[0][0] = if_pc;
		latch_words[0][1] = if_instr;

		latch_words[1][0] = pipe_pkg::pack_ctrl({2'b0, id_exe}, {6'b0, id_mem}, {3'b0, id_wb});
		latch_words[1][1] = id_pc;
		latch_words[1][2] = id_reg_a;
		latch_words[1][3] = id_reg_b;
		latch_words[1][4] = id_instr_ls;
		latch_words[1][5] = pipe_pkg::pack_regid({3'b0, id_rs}, {3'b0, id_rt}, {3'b0, id_rd},
			id_pc_write, id_if_id_write);

		// ex has no exe group, and index 2 stays a hole
		latch_words[2][0] = pipe_pkg::pack_ctrl(8'h00, {5'b0, ex_mem}, {3'b0, ex_wb});
		latch_words[2][1] = ex_pc_jump;
		latch_words[2][3] = ex_alu_result;
		latch_words[2][4] = ex_reg_b;
		latch_words[2][5] = {16'b0, 7'b0, ex_alu_zero, 3'b0, ex_regf_wreg};  // flag byte, reg byte

		latch_words[3][0] = pipe_pkg::pack_ctrl(8'h00, 8'h00, {3'b0, mem_wb});
		latch_words[3][1] = mem_regf_wd;
		latch_words[3][2] = mem_alu_result;
		latch_words[3][3] = {16'b0, 7'b0, mem_pc_sel, 3'b0, mem_regf_wreg};

		latch_words[4][0] = wb_regf_wd;
		latch_words[4][1] = {31'b0, wb_regf_wr};
	end

	////////////////////
	// blocks
	////////////////////

	dbg_cmd_decoder dbg_cmd_decoder_i
	(
		.clk       (clk),
		.rst       (rst),
		.cmd_valid (cmd_valid),
		.cmd_code  (cmd_code),
		.sel       (sel_if)
	);

	// one bank per stage, sized from the command table
	for (genvar g = 0; g < `DBG_NUM_STAGES; g++)
	begin : g_stage
		stage_snapshot #(
			.NUM_WORDS (dbg_pkg::FIELD_COUNT[g])
		) stage_snapshot_i
		(
			.clk         (clk),
			.rst         (rst),
			.freeze      (freeze),
			.latch_words (latch_words[g]),
			.sel         (sel_if),
			.word        (stage_word[g])
		);
	end

	dbg_readout_mux dbg_readout_mux_i
	(
		.clk        (clk),
		.rst        (rst),
		.stage_word (stage_word),
		.sel        (sel_if),
		.out_data   (out_data),
		.out_valid  (out_valid),
		.cmd_error  (cmd_error)
	);

endmodule

//--- design/dbg_readout_mux.sv
`include "dbg_params.svh"

module dbg_readout_mux
(
	input  logic                   clk,
	input  logic                   rst,
	input  pipe_pkg::word_t        stage_word [`DBG_NUM_STAGES],  // one per bank
	dbg_sel_if.mux                 sel,
	output logic [`DBG_WORD_W-1:0] out_data,
	output logic                   out_valid,
	output logic                   cmd_error
);

	pipe_pkg::word_t picked;

	////////////////////
	// stage pick
	////////////////////

	always_comb
	begin
		picked = '0;  // unknown code answers zero
		if (!sel.sel_illegal)
		begin
			case (sel.sel_stage)
				dbg_pkg::STAGE_IF:  picked = stage_word[0];
				dbg_pkg::STAGE_ID:  picked = stage_word[1];
				dbg_pkg::STAGE_EX:  picked = stage_word[2];
				dbg_pkg::STAGE_MEM: picked = stage_word[3];
				dbg_pkg::STAGE_WB:  picked = stage_word[4];
				default:            picked = '0;
			endcase
		end
	end

	////////////////////
	// output regs
	////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_data  <= '0;
			out_valid <= 1'b0;
			cmd_error <= 1'b0;
		end
		else
		begin
			out_valid <= sel.sel_valid;                  // one pulse per read
			cmd_error <= sel.sel_valid & sel.sel_illegal;
			if (sel.sel_valid)
				out_data <= picked;  // held between reads
		end
	end

	// an error never shows without its zero word
	a_error_has_zero_word : assert property
	(
		@(posedge clk) disable iff (rst)
		cmd_error |-> (out_valid && out_data == '0)
	);

endmodule

//--- design/stage_snapshot.sv
`include "dbg_params.svh"

module stage_snapshot #(
	parameter int NUM_WORDS = 2  // valid words of this stage
)
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    freeze,       // high holds the picture
	input  pipe_pkg::stage_words_t  latch_words,  // live latch, packed by top
	dbg_sel_if.bank                 sel,
	output logic [`DBG_WORD_W-1:0]  word
);

	logic [`DBG_WORD_W-1:0] snap [NUM_WORDS];

	////////////////////
	// capture
	////////////////////

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_WORDS; i++)
				snap[i] <= '0;  // clean picture after reset
		end
		else if (!freeze)
		begin
			// follow the latch every cycle
			for (int i = 0; i < NUM_WORDS; i++)
				snap[i] <= latch_words[i];
		end
	end

	////////////////////
	// word select
	////////////////////

	always_comb
	begin
		word = '0;  // index past the bank reads zero
		for (int i = 0; i < NUM_WORDS; i++)
		begin
			if (sel.sel_field == i[`DBG_FIELD_W-1:0])
				word = snap[i];
		end
	end

	// top packing and FIELD_COUNT must agree: nothing live above the count
	a_no_word_past_count : assert property
	(
		@(posedge clk) disable iff (rst)
		!freeze |-> ((latch_words >> (NUM_WORDS * `DBG_WORD_W)) == '0)
	);

endmodule

//--- design/dbg_cmd_decoder.sv
`include "dbg_params.svh"

module dbg_cmd_decoder
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   cmd_valid,  // one cycle strobe from host
	input  logic [`DBG_CODE_W-1:0] cmd_code,
	dbg_sel_if.decoder             sel
);

	dbg_pkg::dbg_cmd_t       cmd;
	logic                    bad_stage;
	logic                    bad_field;
	logic                    illegal;
	logic [`DBG_FIELD_W-1:0] limit;

	////////////////////
	// code check
	////////////////////

	assign cmd = dbg_pkg::dbg_cmd_t'(cmd_code);  // stage on top, field below

	always_comb
	begin
		limit     = dbg_pkg::field_limit(cmd.stage);  // 0 for stage 5..7
		bad_stage = (cmd.stage >= `DBG_STAGE_W'(`DBG_NUM_STAGES));
		bad_field = (cmd.field >= limit);
		// ex index 2 passes here, bank returns zero for it
		illegal   = bad_stage | bad_field;
	end

	////////////////////
	// selection regs
	////////////////////

	// control, cleared on reset
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			sel.sel_valid   <= 1'b0;
			sel.sel_illegal <= 1'b0;
		end
		else
		begin
			sel.sel_valid   <= cmd_valid;
			sel.sel_illegal <= cmd_valid & illegal;  // pulse with valid
		end
	end

	// payload, held until the next strobe
	always_ff @(posedge clk)
	begin
		if (cmd_valid)
		begin
			if (illegal)
			begin
				// park on a harmless word, mux zeroes it anyway
				sel.sel_stage <= dbg_pkg::STAGE_IF;
				sel.sel_field <= '0;
			end
			else
			begin
				sel.sel_stage <= dbg_pkg::stage_e'(cmd.stage);
				sel.sel_field <= cmd.field;
			end
		end
	end

	// a legal pick always lands inside its stage's bank
	a_legal_sel_in_bank : assert property
	(
		@(posedge clk) disable iff (rst)
		(sel.sel_valid && !sel.sel_illegal) |->
			(sel.sel_field < dbg_pkg::field_limit(sel.sel_stage))
	);

endmodule

//--- design/dbg_sel_if.sv
`include "dbg_params.svh"

// decoded selection, one cycle after the strobe
interface dbg_sel_if;

	logic                    sel_valid;    // one cycle pulse per command
	dbg_pkg::stage_e         sel_stage;    // only meaningful when legal
	logic [`DBG_FIELD_W-1:0] sel_field;    // word index within the bank
	logic                    sel_illegal;  // bad stage or index past count

	// decoder owns all of it
	modport decoder
	(
		output sel_valid,
		output sel_stage,
		output sel_field,
		output sel_illegal
	);

	// banks only care which word
	modport bank
	(
		input sel_field
	);

	modport mux
	(
		input sel_valid,
		input sel_stage,
		input sel_field,
		input sel_illegal
	);

endinterface

//--- design/pipe_pkg.sv
`include "dbg_params.svh"

package pipe_pkg;

	////////////////////
	// latch word layout
	////////////////////

	typedef logic [`DBG_WORD_W-1:0] word_t;

	// one bank's worth of words, index 0 in the low bits
	typedef logic [`DBG_MAX_FIELDS-1:0][`DBG_WORD_W-1:0] stage_words_t;

	// control word, one byte per group, each right aligned
	typedef struct packed
	{
		logic [7:0] pad;  // always zero
		logic [7:0] exe;
		logic [7:0] mem;
		logic [7:0] wb;
	} ctrl_word_t;

	// register ids plus the two hazard flags in the low byte
	typedef struct packed
	{
		logic [7:0] rs;
		logic [7:0] rt;
		logic [7:0] rd;
		logic [5:0] pad;
		logic       flag_hi;  // pc write on id
		logic       flag_lo;  // if/id write on id
	} regid_word_t;

	// callers zero extend each group to a byte first
	function automatic ctrl_word_t pack_ctrl(
		input logic [7:0] exe,
		input logic [7:0] mem,
		input logic [7:0] wb
	);
		ctrl_word_t w;
		w.pad = 8'h00;
		w.exe = exe;
		w.mem = mem;
		w.wb  = wb;
		return w;
	endfunction

	function automatic regid_word_t pack_regid(
		input logic [7:0] rs,
		input logic [7:0] rt,
		input logic [7:0] rd,
		input logic       flag_hi,
		input logic       flag_lo
	);
		regid_word_t w;
		w.rs      = rs;
		w.rt      = rt;
		w.rd      = rd;
		w.pad     = 6'b0;
		w.flag_hi = flag_hi;
		w.flag_lo = flag_lo;
		return w;
	endfunction

endpackage

//--- design/dbg_pkg.sv
`include "dbg_params.svh"

package dbg_pkg;

	////////////////////
	// command protocol
	////////////////////

	// stage code, upper bits of the command
	typedef enum logic [`DBG_STAGE_W-1:0]
	{
		STAGE_IF  = 3'd0,
		STAGE_ID  = 3'd1,
		STAGE_EX  = 3'd2,
		STAGE_MEM = 3'd3,
		STAGE_WB  = 3'd4
	} stage_e;

	// raw command, stage kept as plain bits since 5..7 can arrive
	typedef struct packed
	{
		logic [`DBG_STAGE_W-1:0] stage;
		logic [`DBG_FIELD_W-1:0] field;
	} dbg_cmd_t;

	// valid words per stage, ex keeps its hole at index 2
	localparam int unsigned FIELD_COUNT [`DBG_NUM_STAGES] = '{2, 6, 6, 4, 2};

	// word count of a stage, zero for an unknown stage
	function automatic logic [`DBG_FIELD_W-1:0] field_limit(input logic [`DBG_STAGE_W-1:0] stage);
		logic [`DBG_FIELD_W-1:0] lim;
		lim = '0;
		for (int s = 0; s < `DBG_NUM_STAGES; s++)
		begin
			if (stage == s[`DBG_STAGE_W-1:0])
				lim = `DBG_FIELD_W'(FIELD_COUNT[s]);
		end
		return lim;
	endfunction

endpackage

//--- include/dbg_params.svh
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

////////////////////
// debug readout sizes
////////////////////

`define DBG_NUM_STAGES 5   // if, id, ex, mem, wb
`define DBG_WORD_W     32  // one readout word
`define DBG_MAX_FIELDS 8   // words per snapshot bank, worst case

// command code split, stage on top
`define DBG_STAGE_W    3
`define DBG_FIELD_W    4
`define DBG_CODE_W     7   // stage + field

`endif
